//--- Makefile
TOP := tb_dbus_subsys

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) \
		-f dbus_subsys_top.f --Mdir obj_dir
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "=== FAIL ===" sim.log; then \
		echo "result: failed"; exit 1; \
	elif ! grep -q "=== PASS ===" sim.log; then \
		echo "result: no pass line in sim.log"; exit 1; \
	else \
		echo "result: passed"; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- include/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// columns: op, address, byte enables, write data, expected read data, expected bus_err_o
// OP_RD_MEM and OP_RD_GPIN check against the RAM model and gpio_in_i, not the rdata column
task automatic load_vectors();
    // full-word RAM writes and reads, word 255 and wrap past 256 words
    add_vec(OP_WR_RND,    32'h0000_0000, 4'hF, 32'h0,         32'h0,         1'b0);
    add_vec(OP_WR_RND,    32'h0000_0004, 4'hF, 32'h0,         32'h0,         1'b0);
    add_vec(OP_WR,        32'h0000_03FC, 4'hF, 32'hCAFE_0FF0, 32'h0,         1'b0);
    add_vec(OP_RD_MEM,    32'h0000_0000, 4'hF, 32'h0,         32'h0,         1'b0);
    add_vec(OP_RD_MEM,    32'h0000_0004, 4'hF, 32'h0,         32'h0,         1'b0);
    add_vec(OP_RD,        32'h0000_03FC, 4'hF, 32'h0,         32'hCAFE_0FF0, 1'b0);
    add_vec(OP_WR_RND,    32'h0000_0400, 4'hF, 32'h0,         32'h0,         1'b0);
    add_vec(OP_RD_MEM,    32'h0000_0000, 4'hF, 32'h0,         32'h0,         1'b0);
    add_vec(OP_RD_MEM,    32'h0000_0800, 4'hF, 32'h0,         32'h0,         1'b0);
    // partial writes over a known word
    add_vec(OP_WR,        32'h0000_0010, 4'hF, 32'h1122_3344, 32'h0,         1'b0);
    add_vec(OP_RD,        32'h0000_0010, 4'hF, 32'h0,         32'h1122_3344, 1'b0);
    add_vec(OP_WR,        32'h0000_0010, 4'h5, 32'hAABB_CCDD, 32'h0,         1'b0);
    add_vec(OP_RD,        32'h0000_0010, 4'hF, 32'h0,         32'h11BB_33DD, 1'b0);
    add_vec(OP_WR,        32'h0000_0010, 4'h8, 32'h9900_0000, 32'h0,         1'b0);
    add_vec(OP_RD,        32'h0000_0010, 4'hF, 32'h0,         32'h99BB_33DD, 1'b0);
    add_vec(OP_WR_RND,    32'h0000_0004, 4'h5, 32'h0,         32'h0,         1'b0);
    add_vec(OP_RD_MEM,    32'h0000_0004, 4'hF, 32'h0,         32'h0,         1'b0);
    // gpio output, input port, ignored write to the input offset
    add_vec(OP_CHK_GPOUT, 32'h0,         4'h0, 32'h0,         32'h0,         1'b0);
    add_vec(OP_WR,        GPIO_BASE,     4'h3, 32'hDEAD_BEEF, 32'h0,         1'b0);
    add_vec(OP_CHK_GPOUT, 32'h0,         4'h0, 32'h0,         32'h0000_BEEF, 1'b0);
    add_vec(OP_RD,        GPIO_BASE,     4'hF, 32'h0,         32'h0000_BEEF, 1'b0);
    add_vec(OP_WR,        GPIO_BASE,     4'hC, 32'h1234_5678, 32'h0,         1'b0);
    add_vec(OP_RD,        GPIO_BASE,     4'hF, 32'h0,         32'h1234_BEEF, 1'b0);
    add_vec(OP_RD_GPIN,   GPIO_BASE + 4, 4'hF, 32'h0,         32'h0,         1'b0);
    add_vec(OP_WR,        GPIO_BASE + 4, 4'hF, 32'hFFFF_FFFF, 32'h0,         1'b0);
    add_vec(OP_CHK_GPOUT, 32'h0,         4'h0, 32'h0,         32'h1234_BEEF, 1'b0);
    add_vec(OP_RD_GPIN,   GPIO_BASE + 4, 4'hF, 32'h0,         32'h0,         1'b0);
    // ticker: read right after the load, then after three idle cycles
    add_vec(OP_WR,        TICK_BASE,     4'hF, 32'h0000_1000, 32'h0,         1'b0);
    add_vec(OP_RD,        TICK_BASE,     4'hF, 32'h0,         32'h0000_1000, 1'b0);
    add_vec(OP_WR,        TICK_BASE,     4'hF, 32'hFFFF_FFFE, 32'h0,         1'b0);
    add_vec(OP_IDLE,      32'h0,         4'h0, 32'h0,         32'h0,         1'b0);
    add_vec(OP_IDLE,      32'h0,         4'h0, 32'h0,         32'h0,         1'b0);
    add_vec(OP_IDLE,      32'h0,         4'h0, 32'h0,         32'h0,         1'b0);
    add_vec(OP_RD,        TICK_BASE,     4'hF, 32'h0,         32'h0000_0001, 1'b0);
    // unmapped read sets the sticky error
    add_vec(OP_RD,        32'h2000_0000, 4'hF, 32'h0,         32'h0,         1'b1);
    add_vec(OP_RD,        32'h0000_03FC, 4'hF, 32'h0,         32'hCAFE_0FF0, 1'b1);
    add_vec(OP_WR,        GPIO_BASE,     4'hF, 32'h0000_0055, 32'h0,         1'b1);
    add_vec(OP_RD,        GPIO_BASE,     4'hF, 32'h0,         32'h0000_0055, 1'b1);
endtask

`endif

//--- bench/tb_dbus_subsys.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dbus_subsys;
    import soc_bus_pkg::*;

    localparam int RAM_ADDR_W  = 8;
    localparam int RAM_WORDS   = 2 ** RAM_ADDR_W;
    localparam int STALL_LIMIT = 10;
    localparam int DRIVE_DELAY = 2;

    typedef enum logic [2:0] {
        OP_IDLE,
        OP_WR,
        OP_WR_RND,
        OP_RD,
        OP_RD_MEM,
        OP_RD_GPIN,
        OP_CHK_GPOUT
    } op_e;

    typedef struct packed {
        op_e         op;
        logic [31:0] addr;
        logic [3:0]  be;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic        err;
    } vec_t;

    logic        clk;
    logic        arst_n;
    dbus_req_t   req;
    logic [31:0] gpio_in;
    wire [31:0]  rdata;
    wire         stall;
    wire         bus_err;
    wire [31:0]  gpio_out;

    vec_t        vectors [$];
    // reference copy of the RAM contents
    logic [31:0] model_mem [RAM_WORDS];

    dbus_subsys_top #(.RAM_ADDR_W(RAM_ADDR_W)) uut (
        .clk        (clk),
        .arst_n_i   (arst_n),
        .req_i      (req),
        .gpio_in_i  (gpio_in),
        .rdata_o    (rdata),
        .stall_o    (stall),
        .bus_err_o  (bus_err),
        .gpio_out_o (gpio_out)
    );

    always #20 clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic add_vec(input op_e op, input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] wdata, input logic [31:0] rdata,
                           input logic err);
        vec_t v;
        v.op    = op;
        v.addr  = addr;
        v.be    = be;
        v.wdata = wdata;
        v.rdata = rdata;
        v.err   = err;
        vectors.push_back(v);
    endtask

    `include "tb_vectors.svh"

    function automatic logic in_ram_region(input logic [31:0] addr);
        return addr[31:24] == RAM_REGION;
    endfunction

    // fixed bus timing: full write 0, read 1, partial write 2
    function automatic int expected_stalls(input vec_t v);
        if (!in_ram_region(v.addr)) begin
            return 0;
        end
        case (v.op)
            OP_WR, OP_WR_RND:              return (v.be == 4'hF) ? 0 : 2;
            OP_RD, OP_RD_MEM, OP_RD_GPIN:  return 1;
            default:                       return 0;
        endcase
    endfunction

    function automatic int word_index(input logic [31:0] addr);
        return int'((addr >> 2) & 32'(RAM_WORDS - 1));
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] be);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    // counts stall cycles, sampled at the falling edge
    task automatic wait_release(input int idx, output int stalls);
        stalls = 0;
        @(negedge clk);
        while (stall) begin
            stalls++;
            if (stalls > STALL_LIMIT) begin
                stop_run($sformatf("timeout: stall_o held high too long at entry %0d", idx));
            end else begin
                @(negedge clk);
            end
        end
    endtask

    task automatic apply_entry(input int idx, input vec_t v);
        logic [31:0] wdata;
        int          stalls;
        int          widx;
        wdata = v.wdata;
        if (v.op == OP_WR_RND) begin
            wdata = $urandom();
        end
        req       = '0;
        req.addr  = v.addr;
        req.be    = v.be;
        req.wdata = wdata;
        req.wr    = (v.op == OP_WR) || (v.op == OP_WR_RND);
        req.rd    = (v.op == OP_RD) || (v.op == OP_RD_MEM) || (v.op == OP_RD_GPIN);
        widx      = word_index(v.addr);

        wait_release(idx, stalls);
        check_value("stall_o cycles", 32'(stalls), 32'(expected_stalls(v)));
        case (v.op)
            OP_RD:        check_value("rdata_o", rdata, v.rdata);
            OP_RD_MEM:    check_value("rdata_o", rdata, model_mem[widx]);
            OP_RD_GPIN:   check_value("rdata_o", rdata, gpio_in);
            OP_CHK_GPOUT: check_value("gpio_out_o", gpio_out, v.rdata);
            default: begin
            end
        endcase
        if (req.wr && in_ram_region(v.addr)) begin
            model_mem[widx] = merge_bytes(model_mem[widx], wdata, v.be);
        end

        // accepting edge, the error flag updates here
        @(posedge clk);
        #(DRIVE_DELAY);
        check_value("bus_err_o", {31'b0, bus_err}, {31'b0, v.err});
    endtask

    initial begin
        clk     = 1'b0;
        arst_n  = 1'b0;
        req     = '0;
        gpio_in = '0;
        void'($urandom(45732));
        gpio_in = $urandom();
        load_vectors();

        repeat (5) @(posedge clk);
        #(DRIVE_DELAY);
        arst_n = 1'b1;
        @(negedge clk);
        check_value("stall_o", {31'b0, stall}, 32'h0);
        check_value("gpio_out_o", gpio_out, 32'h0);
        check_value("bus_err_o", {31'b0, bus_err}, 32'h0);
        @(posedge clk);
        #(DRIVE_DELAY);

        foreach (vectors[i]) begin
            apply_entry(i, vectors[i]);
        end

        req = '0;
        repeat (2) @(posedge clk);
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- dbus_subsys_top.f
+incdir+include
src/soc_bus_pkg.sv
src/dbus_decode.sv
src/bytes_conv.sv
src/word_ram.sv
src/gpio_regs.sv
src/ticker.sv
src/dbus_result.sv
src/dbus_subsys_top.sv
bench/tb_dbus_subsys.sv

//--- src/bytes_conv.sv
`timescale 1ns/100ps
`default_nettype none

module bytes_conv
    import soc_bus_pkg::*;
#(
    parameter int RAM_ADDR_W = 8
) (
    input  wire            clk,
    input  wire            arst_n_i,
    input  wire dbus_req_t req_i,
    input  wire [31:0]     ram_rdata_i,
    output ram_req_t       ram_req_o,
    output logic [31:0]    rdata_o,
    output logic           stall_o
);

    conv_state_e state_q;
    conv_state_e state_d;
    logic        full_word;
    logic [31:0] merged;

    assign full_word = (req_i.be == 4'hF);

    // enabled bytes of the master data over the old word
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = req_i.be[b] ? req_i.wdata[8*b +: 8] : ram_rdata_i[8*b +: 8];
        end
    end

    always_comb begin
        state_d             = state_q;
        ram_req_o.word_addr = 24'(req_i.addr[RAM_ADDR_W+1:2]);
        ram_req_o.rd        = 1'b0;
        ram_req_o.wr        = 1'b0;
        ram_req_o.wdata     = req_i.wdata;
        stall_o             = 1'b0;
        unique case (state_q)
            CONV_IDLE: begin
                if (req_i.wr && full_word) begin
                    ram_req_o.wr = 1'b1;
                end else if (req_i.rd || req_i.wr) begin
                    // reads and partial writes both start with a word read
                    ram_req_o.rd = 1'b1;
                    stall_o      = 1'b1;
                    state_d      = req_i.wr ? CONV_MERGE : CONV_READ;
                end
            end
            CONV_MERGE: begin
                ram_req_o.wr    = 1'b1;
                ram_req_o.wdata = merged;
                stall_o         = 1'b1;
                state_d         = CONV_READ;
            end
            CONV_READ: begin
                // release cycle, read data is on ram_rdata_i
                state_d = CONV_IDLE;
            end
            default: begin
                state_d = CONV_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= CONV_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign rdata_o = ram_rdata_i;

    // master must hold the access until the converter lets go
    req_stable_during_stall: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        stall_o |=> $stable(req_i)
    ) else $error("bytes_conv: request changed while stalled");

endmodule

`default_nettype wire

//--- src/dbus_decode.sv
`timescale 1ns/100ps
`default_nettype none

module dbus_decode
    import soc_bus_pkg::*;
(
    input  wire dbus_req_t req_i,
    output slave_e         sel_o,
    output dbus_req_t      ram_req_o,
    output slv_req_t       gpio_req_o,
    output slv_req_t       tick_req_o
);

    // address map lookup
    always_comb begin
        if (req_i.addr[31:24] == RAM_REGION) begin
            sel_o = SLV_RAM;
        end else if (req_i.addr[31:8] == GPIO_BASE[31:8]) begin
            sel_o = SLV_GPIO;
        end else if (req_i.addr[31:8] == TICK_BASE[31:8]) begin
            sel_o = SLV_TICK;
        end else begin
            sel_o = SLV_NONE;
        end
    end

    // ram side keeps the full address, converter picks the word bits
    always_comb begin
        ram_req_o    = req_i;
        ram_req_o.rd = req_i.rd && (sel_o == SLV_RAM);
        ram_req_o.wr = req_i.wr && (sel_o == SLV_RAM);
    end

    always_comb begin
        gpio_req_o.offset = req_i.addr[7:0];
        gpio_req_o.be     = req_i.be;
        gpio_req_o.wdata  = req_i.wdata;
        gpio_req_o.rd     = req_i.rd && (sel_o == SLV_GPIO);
        gpio_req_o.wr     = req_i.wr && (sel_o == SLV_GPIO);
    end

    always_comb begin
        tick_req_o.offset = req_i.addr[7:0];
        tick_req_o.be     = req_i.be;
        tick_req_o.wdata  = req_i.wdata;
        tick_req_o.rd     = req_i.rd && (sel_o == SLV_TICK);
        tick_req_o.wr     = req_i.wr && (sel_o == SLV_TICK);
    end

    // master never reads and writes in the same access
    always_comb begin
        assert (!(req_i.rd && req_i.wr))
            else $error("dbus_decode: rd and wr high together");
    end

endmodule

`default_nettype wire

//--- src/dbus_result.sv
`timescale 1ns/100ps
`default_nettype none

module dbus_result
    import soc_bus_pkg::*;
(
    input  wire            clk,
    input  wire            arst_n_i,
    input  wire dbus_req_t req_i,
    input  wire slave_e    sel_i,
    input  wire [31:0]     ram_rdata_i,
    input  wire            ram_stall_i,
    input  wire [31:0]     gpio_rdata_i,
    input  wire [31:0]     tick_rdata_i,
    output logic [31:0]    rdata_o,
    output logic           stall_o,
    output logic           bus_err_o
);

    logic err_q;

    always_comb begin
        case (sel_i)
            SLV_RAM:  rdata_o = ram_rdata_i;
            SLV_GPIO: rdata_o = gpio_rdata_i;
            SLV_TICK: rdata_o = tick_rdata_i;
            default:  rdata_o = UNMAPPED_RDATA;
        endcase
    end

    // only the ram path can hold the master
    assign stall_o = (sel_i == SLV_RAM) ? ram_stall_i : 1'b0;

    // sticky until reset
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            err_q <= 1'b0;
        end else if ((req_i.rd || req_i.wr) && (sel_i == SLV_NONE)) begin
            err_q <= 1'b1;
        end
    end

    assign bus_err_o = err_q;

endmodule

`default_nettype wire

//--- src/dbus_subsys_top.sv
`timescale 1ns/100ps
`default_nettype none

module dbus_subsys_top
    import soc_bus_pkg::*;
#(
    parameter int RAM_ADDR_W = 8
) (
    input  wire            clk,
    input  wire            arst_n_i,
    input  wire dbus_req_t req_i,
    input  wire [31:0]     gpio_in_i,
    output wire [31:0]     rdata_o,
    output wire            stall_o,
    output wire            bus_err_o,
    output wire [31:0]     gpio_out_o
);

    wire slave_e    sel;
    wire dbus_req_t ram_req;
    wire slv_req_t  gpio_req;
    wire slv_req_t  tick_req;
    wire ram_req_t  conv_ram_req;
    wire [31:0]     ram_rdata;
    wire [31:0]     conv_rdata;
    wire [31:0]     gpio_rdata;
    wire [31:0]     tick_rdata;
    wire            conv_stall;

    dbus_decode decode_inst (
        .req_i      (req_i),
        .sel_o      (sel),
        .ram_req_o  (ram_req),
        .gpio_req_o (gpio_req),
        .tick_req_o (tick_req)
    );

    bytes_conv #(.RAM_ADDR_W(RAM_ADDR_W)) mem_conv (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .req_i       (ram_req),
        .ram_rdata_i (ram_rdata),
        .ram_req_o   (conv_ram_req),
        .rdata_o     (conv_rdata),
        .stall_o     (conv_stall)
    );

    word_ram #(.RAM_ADDR_W(RAM_ADDR_W)) mainram (
        .clk       (clk),
        .ram_req_i (conv_ram_req),
        .rdata_o   (ram_rdata)
    );

    gpio_regs gpio_inst (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .req_i      (gpio_req),
        .gpio_in_i  (gpio_in_i),
        .rdata_o    (gpio_rdata),
        .gpio_out_o (gpio_out_o)
    );

    ticker ticker_inst (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .req_i    (tick_req),
        .rdata_o  (tick_rdata)
    );

    dbus_result result_inst (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .req_i        (req_i),
        .sel_i        (sel),
        .ram_rdata_i  (conv_rdata),
        .ram_stall_i  (conv_stall),
        .gpio_rdata_i (gpio_rdata),
        .tick_rdata_i (tick_rdata),
        .rdata_o      (rdata_o),
        .stall_o      (stall_o),
        .bus_err_o    (bus_err_o)
    );

endmodule

`default_nettype wire

//--- src/gpio_regs.sv
`timescale 1ns/100ps
`default_nettype none

module gpio_regs
    import soc_bus_pkg::*;
(
    input  wire           clk,
    input  wire           arst_n_i,
    input  wire slv_req_t req_i,
    input  wire [31:0]    gpio_in_i,
    output logic [31:0]   rdata_o,
    output logic [31:0]   gpio_out_o
);

    logic [31:0] out_q;

    // byte-enabled output register, input offset is read only
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_q <= '0;
        end else if (req_i.wr && (req_i.offset == GPIO_OUT_OFS)) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.be[b]) begin
                    out_q[8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        rdata_o = '0;
        if (req_i.rd) begin
            case (req_i.offset)
                GPIO_OUT_OFS: rdata_o = out_q;
                GPIO_IN_OFS:  rdata_o = gpio_in_i;
                default:      rdata_o = '0;
            endcase
        end
    end

    assign gpio_out_o = out_q;

endmodule

`default_nettype wire

//--- src/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

    // target of a data bus access
    typedef enum logic [1:0] {
        SLV_RAM  = 2'd0,
        SLV_GPIO = 2'd1,
        SLV_TICK = 2'd2,
        SLV_NONE = 2'd3
    } slave_e;

    typedef enum logic [1:0] {
        CONV_IDLE  = 2'd0,
        CONV_READ  = 2'd1,
        CONV_MERGE = 2'd2
    } conv_state_e;

    // master side request
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  be;
        logic        rd;
        logic        wr;
        logic [31:0] wdata;
    } dbus_req_t;

    // peripheral register request, byte offset inside the window
    typedef struct packed {
        logic [7:0]  offset;
        logic [3:0]  be;
        logic        rd;
        logic        wr;
        logic [31:0] wdata;
    } slv_req_t;

    // full-word RAM request
    typedef struct packed {
        logic [23:0] word_addr;
        logic        rd;
        logic        wr;
        logic [31:0] wdata;
    } ram_req_t;

    // address map
    parameter logic [7:0]  RAM_REGION = 8'h00;
    parameter logic [31:0] GPIO_BASE  = 32'h1FD0_F000;
    parameter logic [31:0] TICK_BASE  = 32'h1FD0_E000;

    parameter logic [7:0]  GPIO_OUT_OFS = 8'h00;
    parameter logic [7:0]  GPIO_IN_OFS  = 8'h04;

    parameter logic [31:0] UNMAPPED_RDATA = 32'h0000_0000;

endpackage

`default_nettype wire

//--- src/ticker.sv
`timescale 1ns/100ps
`default_nettype none

module ticker
    import soc_bus_pkg::*;
(
    input  wire           clk,
    input  wire           arst_n_i,
    input  wire slv_req_t req_i,
    output logic [31:0]   rdata_o
);

    localparam logic [7:0] COUNT_OFS = 8'h00;

    logic [31:0] count_q;
    logic        load;

    assign load = req_i.wr && (req_i.offset == COUNT_OFS);

    // loaded value shows the cycle after the write, then counts on
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q <= '0;
        end else if (load) begin
            count_q <= req_i.wdata;
        end else begin
            count_q <= count_q + 32'd1;
        end
    end

    always_comb begin
        if (req_i.rd && (req_i.offset == COUNT_OFS)) begin
            rdata_o = count_q;
        end else begin
            rdata_o = '0;
        end
    end

endmodule

`default_nettype wire

//--- src/word_ram.sv
`timescale 1ns/100ps
`default_nettype none

module word_ram
    import soc_bus_pkg::*;
#(
    parameter int RAM_ADDR_W = 8
) (
    input  wire           clk,
    input  wire ram_req_t ram_req_i,
    output logic [31:0]   rdata_o
);

    localparam int DEPTH = 2 ** RAM_ADDR_W;

    logic [31:0]           mem [DEPTH];
    logic [RAM_ADDR_W-1:0] addr;

    // upper word address bits ignored, so the array wraps
    assign addr = ram_req_i.word_addr[RAM_ADDR_W-1:0];

    always_ff @(posedge clk) begin
        if (ram_req_i.wr) begin
            mem[addr] <= ram_req_i.wdata;
        end
    end

    // registered read, one cycle latency
    always_ff @(posedge clk) begin
        if (ram_req_i.rd) begin
            rdata_o <= mem[addr];
        end
    end

endmodule

`default_nettype wire
